//--- pongCore.f
pongPkg.sv
interruptFront.sv
keyQueue.sv
paddleTrack.sv
ballEngine.sv
gameSequencer.sv
pongCore.sv
pongCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pongCore testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary -f pongCore.f --top-module pongCoreTb -o pongSim \
	&& ./obj_dir/pongSim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"
grep -q ">>> PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- pongCoreTb.sv
`timescale 1ns/10ps

module pongCoreTb;

	localparam int queueDepthLog2 = 4;
	localparam int queueDepth = 2 ** queueDepthLog2;
	localparam int scoreLimit = 5;
	localparam int ackLimit = 20;
	localparam int endLimit = 200;
	localparam int paddleKeys = 60;
	localparam int flightTicks = 40;
	localparam int pointTickLimit = 300;
	localparam int winTickLimit = pointTickLimit * (2 * scoreLimit - 1);
	// Each play tick may carry a launch and a paddle key besides the timer
	localparam int plannedIrqs = 1 + 2 * paddleKeys + 21 + 3 * flightTicks +
		3 * pointTickLimit + 3 * winTickLimit + 10;
	localparam longint watchdogNs = longint'(plannedIrqs) * 300 * 10;

	logic CLK = 1'b0;
	logic resetBall;
	pongPkg::irqKindT irq;
	pongPkg::keyCodeT kbdKey;
	logic iack;
	logic iend;
	pongPkg::coordT leftPaddlePos;
	pongPkg::coordT rightPaddlePos;
	pongPkg::coordT ballX;
	pongPkg::coordT ballY;
	pongPkg::scoreT scoreLeft;
	pongPkg::scoreT scoreRight;
	pongPkg::winnerT winner;

	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;

	// Reference model state
	int mLeft;
	int mRight;
	int mBallX;
	int mBallY;
	bit mDirLeft;
	bit mDirUp;
	int mSpeed;
	pongPkg::ballModeT mMode;
	int mScoreL;
	int mScoreR;
	pongPkg::winnerT mWinner;
	pongPkg::keyCodeT mQueue[$];

	pongCore #(
		.queueDepthLog2(queueDepthLog2),
		.scoreLimit(scoreLimit)
	) pongCore_i (
		.CLK(CLK),
		.resetBall(resetBall),
		.irq(irq),
		.kbdKey(kbdKey),
		.iack(iack),
		.iend(iend),
		.leftPaddlePos(leftPaddlePos),
		.rightPaddlePos(rightPaddlePos),
		.ballX(ballX),
		.ballY(ballY),
		.scoreLeft(scoreLeft),
		.scoreRight(scoreRight),
		.winner(winner)
	);

	always #5 CLK = ~CLK;

	initial begin
		#(watchdogNs);
		$display("watchdog expired at %0t, the interrupt sequence did not complete", $time);
		$display(">>> FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic compareCoord(input string name, input pongPkg::coordT expected,
		input pongPkg::coordT actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareScore(input string name, input pongPkg::scoreT expected,
		input pongPkg::scoreT actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareWinner(input string name, input pongPkg::winnerT expected,
		input pongPkg::winnerT actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %s actual %s", $time, name,
				expected.name(), actual.name());
			errorCount++;
		end
	endtask

	task automatic checkState();
		compareCoord("leftPaddlePos", pongPkg::coordT'(mLeft), leftPaddlePos);
		compareCoord("rightPaddlePos", pongPkg::coordT'(mRight), rightPaddlePos);
		compareCoord("ballX", pongPkg::coordT'(mBallX), ballX);
		compareCoord("ballY", pongPkg::coordT'(mBallY), ballY);
		compareScore("scoreLeft", pongPkg::scoreT'(mScoreL), scoreLeft);
		compareScore("scoreRight", pongPkg::scoreT'(mScoreR), scoreRight);
		compareWinner("winner", mWinner, winner);
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic bit inSpan(input int pos, input int y);
		return (y >= pos - int'(pongPkg::paddleHalf)) && (y < pos + int'(pongPkg::paddleHalf));
	endfunction

	task automatic modelServe(input bit fromLeft);
		mBallX = fromLeft ? int'(pongPkg::leftServeX) : int'(pongPkg::rightServeX);
		mBallY = fromLeft ? mLeft : mRight;
		mDirLeft = !fromLeft;
		mDirUp = 1'b0;
		mSpeed = 1;
		mMode = fromLeft ? pongPkg::serveLeft : pongPkg::serveRight;
	endtask

	task automatic modelApplyKey(input pongPkg::keyCodeT key);
		case (key)
			pongPkg::keyLeftUp:
				if (mLeft > int'(pongPkg::paddleTop))
					mLeft--;
			pongPkg::keyLeftDown:
				if (mLeft < int'(pongPkg::paddleBottom))
					mLeft++;
			pongPkg::keyRightUp:
				if (mRight > int'(pongPkg::paddleTop))
					mRight--;
			pongPkg::keyRightDown:
				if (mRight < int'(pongPkg::paddleBottom))
					mRight++;
			pongPkg::keyLaunch: mMode = pongPkg::flying;
			default: ;
		endcase
	endtask

	task automatic modelBallStep();
		int nextX;
		int nextY;
		bit stopped;
		bit edgeRow;
		if (mMode != pongPkg::flying) begin
			modelServe(mMode == pongPkg::serveLeft);
			return;
		end
		stopped = 1'b0;
		for (int n = 0; n < mSpeed && !stopped; n++) begin
			mBallX = mDirLeft ? mBallX - 1 : mBallX + 1;
			mBallY = mDirUp ? mBallY - 1 : mBallY + 1;
			nextX = mDirLeft ? mBallX - 1 : mBallX + 1;
			nextY = mDirUp ? mBallY - 1 : mBallY + 1;
			edgeRow = (mBallY == 0) || (mBallY == int'(pongPkg::fieldBottom));
			if ((nextX == int'(pongPkg::leftHitX) && inSpan(mLeft, nextY)) ||
				(nextX == int'(pongPkg::rightHitX) && inSpan(mRight, nextY))) begin
				mDirLeft = !mDirLeft;
				if (mSpeed < int'(pongPkg::maxSpeed))
					mSpeed++;
				if (edgeRow)
					mDirUp = !mDirUp;
				stopped = 1'b1;
			end else if (mBallX == 0 || mBallX == int'(pongPkg::fieldRight)) begin
				stopped = 1'b1;
			end else if (edgeRow) begin
				mDirUp = !mDirUp;
				stopped = 1'b1;
			end
		end
		if (mBallX == 0) begin
			mScoreR++;
			modelServe(1'b1);
		end else if (mBallX == int'(pongPkg::fieldRight)) begin
			mScoreL++;
			modelServe(1'b0);
		end
	endtask

	task automatic modelTick();
		pongPkg::keyCodeT key;
		while (mQueue.size() > 0) begin
			key = mQueue.pop_front();
			if (mWinner == pongPkg::noWinner)
				modelApplyKey(key);
		end
		if (mWinner == pongPkg::noWinner) begin
			modelBallStep();
			if (mScoreL >= scoreLimit)
				mWinner = pongPkg::leftWins;
			else if (mScoreR >= scoreLimit)
				mWinner = pongPkg::rightWins;
		end
	endtask

	////////////////////////////////////////
	// Interrupt handshake
	////////////////////////////////////////

	task automatic issueIrq(input pongPkg::irqKindT kind, input pongPkg::keyCodeT code);
		int waitCount;
		@(posedge CLK);
		irq <= kind;
		kbdKey <= code;
		waitCount = 0;
		@(negedge CLK);
		while (!iack && waitCount < ackLimit) begin
			@(negedge CLK);
			waitCount++;
		end
		if (!iack) begin
			$display("error at %0t: interrupt request was never acknowledged", $time);
			errorCount++;
		end
		@(posedge CLK);
		irq <= pongPkg::irqIdle;
		waitCount = 0;
		@(negedge CLK);
		while (!iend && waitCount < endLimit) begin
			@(negedge CLK);
			waitCount++;
		end
		if (!iend) begin
			$display("error at %0t: interrupt never signalled its end", $time);
			errorCount++;
		end
	endtask

	task automatic sendKey(input pongPkg::keyCodeT key);
		issueIrq(pongPkg::irqKey, key);
		if (mQueue.size() < queueDepth)
			mQueue.push_back(key);
	endtask

	task automatic sendTick();
		issueIrq(pongPkg::irqTimer, 8'h00);
		modelTick();
		checkState();
	endtask

	function automatic pongPkg::keyCodeT paddleKey();
		case ($urandom_range(0, 3))
			0: return pongPkg::keyLeftUp;
			1: return pongPkg::keyLeftDown;
			2: return pongPkg::keyRightUp;
			default: return pongPkg::keyRightDown;
		endcase
	endfunction

	// Mostly game keys with an arbitrary code now and then
	function automatic pongPkg::keyCodeT randomKey();
		int pick;
		pick = int'($urandom_range(0, 9));
		if (pick < 8)
			return paddleKey();
		else if (pick == 8)
			return pongPkg::keyLaunch;
		return pongPkg::keyCodeT'($urandom_range(0, 255));
	endfunction

	task automatic playTick();
		if (mMode != pongPkg::flying)
			sendKey(pongPkg::keyLaunch);
		if ($urandom_range(0, 1) == 0)
			sendKey(paddleKey());
		sendTick();
	endtask

	task automatic endTest(input string name, input int errorsAtStart);
		testCount++;
		if (errorCount == errorsAtStart) begin
			$display("test %s ok", name);
		end else begin
			failedTests++;
			$display("test %s failed with %0d errors", name, errorCount - errorsAtStart);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int errorsAtStart;
		int runLength;
		int keysSent;
		int pointsBefore;
		int tickCount;
		pongPkg::keyCodeT key;
		pongPkg::coordT snapLeft;
		pongPkg::coordT snapRight;
		pongPkg::coordT snapX;
		pongPkg::coordT snapY;
		pongPkg::scoreT snapScoreL;
		pongPkg::scoreT snapScoreR;

		void'($urandom(63));
		resetBall = 1'b1;
		irq = pongPkg::irqIdle;
		kbdKey = 8'h00;
		mLeft = int'(pongPkg::paddleCenter);
		mRight = int'(pongPkg::paddleCenter);
		mBallX = 0;
		mBallY = 0;
		mDirLeft = 1'b0;
		mDirUp = 1'b0;
		mSpeed = 0;
		mMode = pongPkg::serveLeft;
		mScoreL = 0;
		mScoreR = 0;
		mWinner = pongPkg::noWinner;
		repeat (5) @(posedge CLK);
		resetBall <= 1'b0;

		// Serve position after the first tick
		errorsAtStart = errorCount;
		sendTick();
		compareCoord("leftPaddlePos", pongPkg::paddleCenter, leftPaddlePos);
		compareCoord("rightPaddlePos", pongPkg::paddleCenter, rightPaddlePos);
		compareCoord("ballX", pongPkg::leftServeX, ballX);
		compareCoord("ballY", pongPkg::paddleCenter, ballY);
		compareScore("scoreLeft", 4'd0, scoreLeft);
		compareScore("scoreRight", 4'd0, scoreRight);
		endTest("resetState", errorsAtStart);

		// Runs of one key push the paddles into their limits
		errorsAtStart = errorCount;
		keysSent = 0;
		while (keysSent < paddleKeys) begin
			key = paddleKey();
			runLength = int'($urandom_range(1, 8));
			for (int n = 0; n < runLength && keysSent < paddleKeys; n++) begin
				sendKey(key);
				sendTick();
				keysSent++;
				if (leftPaddlePos < pongPkg::paddleTop || leftPaddlePos > pongPkg::paddleBottom ||
					rightPaddlePos < pongPkg::paddleTop ||
					rightPaddlePos > pongPkg::paddleBottom) begin
					$display("error at %0t: a paddle left its travel range", $time);
					errorCount++;
				end
			end
		end
		endTest("paddleLimits", errorsAtStart);

		// Keys past the queue depth are lost
		errorsAtStart = errorCount;
		for (int n = 0; n < 20; n++)
			sendKey(paddleKey());
		sendTick();
		endTest("queueOverflow", errorsAtStart);

		errorsAtStart = errorCount;
		for (int n = 0; n < flightTicks; n++)
			playTick();
		endTest("ballFlight", errorsAtStart);

		errorsAtStart = errorCount;
		pointsBefore = mScoreL + mScoreR;
		tickCount = 0;
		while (mScoreL + mScoreR == pointsBefore && tickCount < pointTickLimit) begin
			playTick();
			tickCount++;
		end
		if (mScoreL + mScoreR == pointsBefore) begin
			$display("error at %0t: no point was scored within %0d ticks", $time, tickCount);
			errorCount++;
		end else if (mMode == pongPkg::serveLeft) begin
			compareCoord("ballX", pongPkg::leftServeX, ballX);
		end else begin
			compareCoord("ballX", pongPkg::rightServeX, ballX);
		end
		endTest("scoring", errorsAtStart);

		// Play on until a winner and check that nothing moves after it
		errorsAtStart = errorCount;
		tickCount = 0;
		while (mWinner == pongPkg::noWinner && tickCount < winTickLimit) begin
			playTick();
			tickCount++;
		end
		if (mWinner == pongPkg::noWinner) begin
			$display("error at %0t: no winner after %0d ticks", $time, tickCount);
			errorCount++;
		end
		snapLeft = pongPkg::coordT'(mLeft);
		snapRight = pongPkg::coordT'(mRight);
		snapX = pongPkg::coordT'(mBallX);
		snapY = pongPkg::coordT'(mBallY);
		snapScoreL = pongPkg::scoreT'(mScoreL);
		snapScoreR = pongPkg::scoreT'(mScoreR);
		for (int n = 0; n < 4; n++) begin
			sendKey(randomKey());
			sendKey(pongPkg::keyLaunch);
			sendTick();
		end
		compareCoord("leftPaddlePos", snapLeft, leftPaddlePos);
		compareCoord("rightPaddlePos", snapRight, rightPaddlePos);
		compareCoord("ballX", snapX, ballX);
		compareCoord("ballY", snapY, ballY);
		compareScore("scoreLeft", snapScoreL, scoreLeft);
		compareScore("scoreRight", snapScoreR, scoreRight);
		endTest("winnerFreeze", errorsAtStart);

		$display("tests run %0d, tests failed %0d, errors %0d", testCount, failedTests,
			errorCount);
		if (errorCount == 0 && failedTests == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- pongCore.sv
`timescale 1ns/10ps

module pongCore #(
	parameter int queueDepthLog2 = 4,
	parameter int scoreLimit = 5
) (
	input logic CLK,
	input logic resetBall,
	input pongPkg::irqKindT irq,
	input pongPkg::keyCodeT kbdKey,
	output logic iack,
	output logic iend,
	output pongPkg::coordT leftPaddlePos,
	output pongPkg::coordT rightPaddlePos,
	output pongPkg::coordT ballX,
	output pongPkg::coordT ballY,
	output pongPkg::scoreT scoreLeft,
	output pongPkg::scoreT scoreRight,
	output pongPkg::winnerT winner
);

	////////////////////////////////////////
	// Internal links
	////////////////////////////////////////

	logic tickStart;
	logic tickDone;
	logic pushValid;
	pongPkg::keyCodeT pushKey;
	logic popValid;
	logic popReady;
	pongPkg::keyCodeT popKey;
	logic leftUp;
	logic leftDown;
	logic rightUp;
	logic rightDown;
	logic launch;
	logic stepStart;
	logic stepDone;
	logic pointLeft;
	logic pointRight;

	interruptFront irqFront (
		.CLK(CLK),
		.resetBall(resetBall),
		.irq(irq),
		.kbdKey(kbdKey),
		.tickDone(tickDone),
		.iack(iack),
		.iend(iend),
		.tickStart(tickStart),
		.pushValid(pushValid),
		.pushKey(pushKey)
	);

	keyQueue #(
		.queueDepthLog2(queueDepthLog2)
	) keyFifo (
		.CLK(CLK),
		.resetBall(resetBall),
		.pushValid(pushValid),
		.pushKey(pushKey),
		.popReady(popReady),
		.popValid(popValid),
		.popKey(popKey)
	);

	gameSequencer #(
		.scoreLimit(scoreLimit)
	) sequencer (
		.CLK(CLK),
		.resetBall(resetBall),
		.tickStart(tickStart),
		.popValid(popValid),
		.popKey(popKey),
		.stepDone(stepDone),
		.pointLeft(pointLeft),
		.pointRight(pointRight),
		.popReady(popReady),
		.tickDone(tickDone),
		.leftUp(leftUp),
		.leftDown(leftDown),
		.rightUp(rightUp),
		.rightDown(rightDown),
		.launch(launch),
		.stepStart(stepStart),
		.scoreLeft(scoreLeft),
		.scoreRight(scoreRight),
		.winner(winner)
	);

	paddleTrack leftPaddle (
		.CLK(CLK),
		.resetBall(resetBall),
		.moveUp(leftUp),
		.moveDown(leftDown),
		.pos(leftPaddlePos)
	);

	paddleTrack rightPaddle (
		.CLK(CLK),
		.resetBall(resetBall),
		.moveUp(rightUp),
		.moveDown(rightDown),
		.pos(rightPaddlePos)
	);

	ballEngine ballUnit (
		.CLK(CLK),
		.resetBall(resetBall),
		.launch(launch),
		.stepStart(stepStart),
		.leftPaddlePos(leftPaddlePos),
		.rightPaddlePos(rightPaddlePos),
		.stepDone(stepDone),
		.pointLeft(pointLeft),
		.pointRight(pointRight),
		.ballX(ballX),
		.ballY(ballY)
	);

endmodule

//--- gameSequencer.sv
`timescale 1ns/10ps

module gameSequencer #(
	parameter int scoreLimit = 5
) (
	input logic CLK,
	input logic resetBall,
	input logic tickStart,
	input logic popValid,
	input pongPkg::keyCodeT popKey,
	input logic stepDone,
	input logic pointLeft,
	input logic pointRight,
	output logic popReady,
	output logic tickDone,
	output logic leftUp,
	output logic leftDown,
	output logic rightUp,
	output logic rightDown,
	output logic launch,
	output logic stepStart,
	output pongPkg::scoreT scoreLeft,
	output pongPkg::scoreT scoreRight,
	output pongPkg::winnerT winner
);

	typedef enum logic [2:0] {
		stIdle,
		stDrain,
		stPop,
		stStep,
		stWaitStep,
		stFinish
	} stateT;

	localparam pongPkg::scoreT limitScore = pongPkg::scoreT'(scoreLimit);

	stateT state;
	logic frozen;
	logic applyKey;

	assign frozen = winner != pongPkg::noWinner;

	////////////////////////////////////////
	// Key decode
	////////////////////////////////////////

	// Keys still drain after a win but do nothing
	assign applyKey = (state == stPop) && !frozen;
	assign popReady = state == stPop;

	assign leftUp = applyKey && (popKey == pongPkg::keyLeftUp);
	assign leftDown = applyKey && (popKey == pongPkg::keyLeftDown);
	assign rightUp = applyKey && (popKey == pongPkg::keyRightUp);
	assign rightDown = applyKey && (popKey == pongPkg::keyRightDown);
	assign launch = applyKey && (popKey == pongPkg::keyLaunch);

	assign stepStart = (state == stStep) && !frozen;
	assign tickDone = state == stFinish;

	////////////////////////////////////////
	// Tick FSM
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					if (tickStart)
						state <= stDrain;
				end
				// Two cycles per key so the count settles before the next look
				stDrain: state <= popValid ? stPop : stStep;
				stPop: state <= stDrain;
				stStep: state <= frozen ? stFinish : stWaitStep;
				stWaitStep: begin
					if (stepDone)
						state <= stFinish;
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Points arrive together with the end of the ball step
	always_ff @(posedge CLK) begin
		if (resetBall) begin
			scoreLeft <= '0;
			scoreRight <= '0;
		end else if ((state == stWaitStep) && stepDone) begin
			if (pointLeft)
				scoreLeft <= scoreLeft + 4'd1;
			if (pointRight)
				scoreRight <= scoreRight + 4'd1;
		end
	end

	// Winner latches once and freezes the game
	always_ff @(posedge CLK) begin
		if (resetBall) begin
			winner <= pongPkg::noWinner;
		end else if ((state == stFinish) && !frozen) begin
			if (scoreLeft >= limitScore)
				winner <= pongPkg::leftWins;
			else if (scoreRight >= limitScore)
				winner <= pongPkg::rightWins;
		end
	end

endmodule

//--- ballEngine.sv
`timescale 1ns/10ps

module ballEngine (
	input logic CLK,
	input logic resetBall,
	input logic launch,
	input logic stepStart,
	input pongPkg::coordT leftPaddlePos,
	input pongPkg::coordT rightPaddlePos,
	output logic stepDone,
	output logic pointLeft,
	output logic pointRight,
	output pongPkg::coordT ballX,
	output pongPkg::coordT ballY
);

	typedef enum logic [1:0] {
		stIdle,
		stMove,
		stCheck,
		stDone
	} stateT;

	stateT state;
	pongPkg::ballModeT mode;
	logic dirLeft;
	logic dirUp;
	logic [2:0] speed;
	logic [2:0] subCount;
	pongPkg::coordT nextX;
	pongPkg::coordT nextY;
	logic leftContact;
	logic rightContact;
	logic atSideWall;
	logic atTopBottom;
	logic moveNow;
	logic serveLeftNow;
	logic serveRightNow;

	////////////////////////////////////////
	// Look-ahead
	////////////////////////////////////////

	// Cell the ball would enter with its present direction
	assign nextX = dirLeft ? ballX - 8'd1 : ballX + 8'd1;
	assign nextY = dirUp ? ballY - 8'd1 : ballY + 8'd1;

	assign leftContact = (nextX == pongPkg::leftHitX) &&
		(nextY >= leftPaddlePos - pongPkg::paddleHalf) &&
		(nextY < leftPaddlePos + pongPkg::paddleHalf);
	assign rightContact = (nextX == pongPkg::rightHitX) &&
		(nextY >= rightPaddlePos - pongPkg::paddleHalf) &&
		(nextY < rightPaddlePos + pongPkg::paddleHalf);

	assign atSideWall = (ballX == 8'd0) || (ballX == pongPkg::fieldRight);
	assign atTopBottom = (ballY == 8'd0) || (ballY == pongPkg::fieldBottom);

	assign moveNow = (state == stMove) && (subCount < speed);

	// Serve on request while parked, or after a miss at either wall
	assign serveLeftNow = ((state == stIdle) && stepStart && (mode == pongPkg::serveLeft)) ||
		((state == stDone) && (ballX == 8'd0));
	assign serveRightNow = ((state == stIdle) && stepStart && (mode == pongPkg::serveRight)) ||
		((state == stDone) && (ballX == pongPkg::fieldRight));

	assign stepDone = state == stDone;
	assign pointRight = (state == stDone) && (ballX == 8'd0);
	assign pointLeft = (state == stDone) && (ballX == pongPkg::fieldRight);

	////////////////////////////////////////
	// Step sequencing
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			state <= stIdle;
			subCount <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (stepStart) begin
						subCount <= '0;
						state <= (mode == pongPkg::flying) ? stMove : stDone;
					end
				end
				stMove: state <= moveNow ? stCheck : stDone;
				stCheck: begin
					// Any contact or wall ends the step early
					if (leftContact || rightContact || atSideWall || atTopBottom) begin
						state <= stDone;
					end else begin
						subCount <= subCount + 3'd1;
						state <= stMove;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	////////////////////////////////////////
	// Ball state
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			ballX <= 8'd0;
			ballY <= 8'd0;
			dirLeft <= 1'b0;
			dirUp <= 1'b0;
			speed <= 3'd0;
			mode <= pongPkg::serveLeft;
		end else if (serveLeftNow) begin
			ballX <= pongPkg::leftServeX;
			ballY <= leftPaddlePos;
			dirLeft <= 1'b0;
			dirUp <= 1'b0;
			speed <= 3'd1;
			mode <= pongPkg::serveLeft;
		end else if (serveRightNow) begin
			ballX <= pongPkg::rightServeX;
			ballY <= rightPaddlePos;
			dirLeft <= 1'b1;
			dirUp <= 1'b0;
			speed <= 3'd1;
			mode <= pongPkg::serveRight;
		end else begin
			if (launch)
				mode <= pongPkg::flying;
			if (moveNow) begin
				ballX <= nextX;
				ballY <= nextY;
			end
			if (state == stCheck) begin
				if (leftContact || rightContact) begin
					dirLeft <= !dirLeft;
					if (speed < pongPkg::maxSpeed)
						speed <= speed + 3'd1;
					// Corner hit also turns the ball vertically
					if (atTopBottom)
						dirUp <= !dirUp;
				end else if (!atSideWall && atTopBottom) begin
					dirUp <= !dirUp;
				end
			end
		end
	end

endmodule

//--- paddleTrack.sv
`timescale 1ns/10ps

module paddleTrack (
	input logic CLK,
	input logic resetBall,
	input logic moveUp,
	input logic moveDown,
	output pongPkg::coordT pos
);

	logic canRise;
	logic canFall;

	// Travel stops at the limit rows
	assign canRise = pos > pongPkg::paddleTop;
	assign canFall = pos < pongPkg::paddleBottom;

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			pos <= pongPkg::paddleCenter;
		end else if (moveUp) begin
			if (canRise)
				pos <= pos - 8'd1;
		end else if (moveDown) begin
			if (canFall)
				pos <= pos + 8'd1;
		end
	end

endmodule

//--- keyQueue.sv
`timescale 1ns/10ps

module keyQueue #(
	parameter int queueDepthLog2 = 4
) (
	input logic CLK,
	input logic resetBall,
	input logic pushValid,
	input pongPkg::keyCodeT pushKey,
	input logic popReady,
	output logic popValid,
	output pongPkg::keyCodeT popKey
);

	localparam int depth = 2 ** queueDepthLog2;

	pongPkg::keyCodeT store [depth];
	logic [queueDepthLog2-1:0] front;
	logic [queueDepthLog2-1:0] back;
	logic [queueDepthLog2:0] count;
	logic full;
	logic doPush;
	logic doPop;

	assign full = count == (queueDepthLog2 + 1)'(depth);

	// A key that finds the queue full is lost
	assign doPush = pushValid && !full;
	assign doPop = popReady && popValid;

	assign popValid = count != '0;
	assign popKey = store[front];

	always_ff @(posedge CLK) begin
		if (doPush)
			store[back] <= pushKey;
	end

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			front <= '0;
			back <= '0;
			count <= '0;
		end else begin
			if (doPush)
				back <= back + queueDepthLog2'(1);
			if (doPop)
				front <= front + queueDepthLog2'(1);
			// Simultaneous push and pop leave the count alone
			case ({doPush, doPop})
				2'b10: count <= count + (queueDepthLog2 + 1)'(1);
				2'b01: count <= count - (queueDepthLog2 + 1)'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

//--- interruptFront.sv
`timescale 1ns/10ps

module interruptFront (
	input logic CLK,
	input logic resetBall,
	input pongPkg::irqKindT irq,
	input pongPkg::keyCodeT kbdKey,
	input logic tickDone,
	output logic iack,
	output logic iend,
	output logic tickStart,
	output logic pushValid,
	output pongPkg::keyCodeT pushKey
);

	typedef enum logic [2:0] {
		stIdle,
		stKeyAck,
		stKeyCapture,
		stKeyPush,
		stTickAck,
		stTickStart,
		stTickWait,
		stEnd
	} stateT;

	stateT state;
	stateT nextState;
	pongPkg::keyCodeT keyLatch;

	always_ff @(posedge CLK) begin
		if (resetBall)
			state <= stIdle;
		else
			state <= nextState;
	end

	// Keyboard still holds the code one cycle past the acknowledge
	always_ff @(posedge CLK) begin
		if (state == stKeyCapture)
			keyLatch <= kbdKey;
	end

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				// Anything else counts as idle
				if (irq == pongPkg::irqKey)
					nextState = stKeyAck;
				else if (irq == pongPkg::irqTimer)
					nextState = stTickAck;
			end
			stKeyAck: nextState = stKeyCapture;
			stKeyCapture: nextState = stKeyPush;
			stKeyPush: nextState = stEnd;
			stTickAck: nextState = stTickStart;
			stTickStart: nextState = stTickWait;
			stTickWait: begin
				if (tickDone)
					nextState = stEnd;
			end
			default: nextState = stIdle;
		endcase
	end

	assign iack = (state == stKeyAck) || (state == stTickAck);
	assign iend = state == stEnd;
	assign tickStart = state == stTickStart;
	assign pushValid = state == stKeyPush;
	assign pushKey = keyLatch;

endmodule

//--- pongPkg.sv
package pongPkg;

	////////////////////////////////////////
	// Basic words
	////////////////////////////////////////

	typedef logic [7:0] coordT;
	typedef logic [7:0] keyCodeT;
	typedef logic [3:0] scoreT;

	// Interrupt request code where 3 also means idle
	typedef enum logic [1:0] {
		irqTimer = 2'd0,
		irqKey = 2'd1,
		irqIdle = 2'd2
	} irqKindT;

	typedef enum logic [1:0] {
		serveLeft = 2'd0,
		serveRight = 2'd1,
		flying = 2'd2
	} ballModeT;

	typedef enum logic [1:0] {
		noWinner = 2'd0,
		leftWins = 2'd1,
		rightWins = 2'd2
	} winnerT;

	////////////////////////////////////////
	// Field geometry
	////////////////////////////////////////

	localparam coordT fieldRight = 8'd63;
	localparam coordT fieldBottom = 8'd17;

	// Paddle spans pos-2 up to pos+1
	localparam coordT paddleCenter = 8'd9;
	localparam coordT paddleTop = 8'd2;
	localparam coordT paddleBottom = 8'd16;
	localparam coordT paddleHalf = 8'd2;

	localparam coordT leftHitX = 8'd2;
	localparam coordT rightHitX = 8'd61;
	localparam coordT leftServeX = 8'd3;
	localparam coordT rightServeX = 8'd60;

	localparam logic [2:0] maxSpeed = 3'd5;

	// Game keys in plain ASCII
	localparam keyCodeT keyLeftUp = 8'h77;
	localparam keyCodeT keyLeftDown = 8'h73;
	localparam keyCodeT keyRightUp = 8'h69;
	localparam keyCodeT keyRightDown = 8'h6B;
	localparam keyCodeT keyLaunch = 8'h20;

endpackage
